// ==== compile.f ====
verilog/mmu_pkg.sv
verilog/tlb_entry.sv
verilog/tlb_write_port.sv
verilog/tlb_lookup.sv
verilog/mmu.sv
verilog/mmu_top.sv
tb/mmu_assert.sv
tb/mmu_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --timing --assert
TOP       ?= mmu_tb
FILELIST  ?= compile.f
OBJ_DIR   ?= obj_dir
PASS_MSG  := Verification passed

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP) 2>&1)"; echo "$$out"; echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// ==== tb/mmu_tb.sv ====
// MMU testbench
// Random accesses and TLB writes on the data port, checked against a reference TLB model.
`timescale 1ns/1ps

module mmu_tb
    import mmu_pkg::*;
();

    localparam int N_OPS      = 800;
    localparam int MAX_CYCLES = 40 * N_OPS; // generous bound per access or write

    typedef struct packed {
        logic        en;
        logic [3:0]  wen;
        logic [31:0] rdata;
        logic [31:0] wdata;
    } bus_obs_t;

    logic              clk = 1'b0;
    logic              rst_n;
    logic              en, bus_en, bus_stall, bus_cached, exc_flag, stall;
    logic              exc_refill, exc_invalid, exc_modified, tlb_wi, tlb_wr;
    logic [3:0]        wen, bus_wen;
    logic [31:0]       vaddr, wdata, rdata, bus_paddr, bus_wdata, bus_rdata;
    logic [31:0]       cp0_status, cp0_config;
    logic [ASID_W-1:0] asid;
    tlb_idx_t          tlb_index;
    tlb_rec_t          tlb_wdata;

    tlb_rec_t    model_tlb [TLB_ENTRIES]; // reference copy of the entries
    tlb_idx_t    model_ptr;
    tlb_req_t    last_req;                // request held in the lookup register
    logic        last_valid;
    logic [31:0] lfsr = 32'd42;
    int          cycles = 0;

    mmu_top mmu_top_i (.*);

    always #4 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("ERROR: run did not finish within %0d cycles", MAX_CYCLES);
            $display("Verification failed");
            $fatal(1, "timeout");
        end
    end

    // x^32 + x^22 + x^2 + x + 1, one step per bit
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        logic        fb;
        r = '0;
        for (int k = 0; k < n; k++) begin
            fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            r    = {r[30:0], fb};
        end
        return r;
    endfunction

    function automatic page_lo_t rand_lo();
        page_lo_t p;
        p.pfn   = 20'(rand_bits(20));
        p.cca   = 3'(rand_bits(3));
        p.dirty = rand_bits(1) != 0;
        p.valid = rand_bits(2) != 0; // mostly valid
        return p;
    endfunction

    // small vpn2 pool in kuseg and kseg2 so lookups hit often
    function automatic tlb_rec_t rand_rec();
        tlb_rec_t r;
        r.vpn2   = {(rand_bits(1) != 0) ? 3'b110 : 3'b000, 14'd0, 2'(rand_bits(2))};
        r.asid   = ASID_W'(rand_bits(1));
        r.global = rand_bits(2) == 0;
        r.lo0    = rand_lo();
        r.lo1    = rand_lo();
        return r;
    endfunction

    task automatic check_paddr(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
        if (exp !== act) begin
            $display("[FAIL] %s paddr: expected %h, actual %h", name, exp, act);
            $display("Verification failed");
            $fatal(1, "paddr mismatch");
        end
    endtask

    task automatic check_rsp(input string name, input tlb_rsp_t exp, input tlb_rsp_t act);
        if (exp !== act) begin
            $display("[FAIL] %s rdy/cached/refill/invalid/modified: expected %b, actual %b",
                     name, {exp.rdy, exp.cached, exp.refill, exp.invalid, exp.modified},
                     {act.rdy, act.cached, act.refill, act.invalid, act.modified});
            $display("Verification failed");
            $fatal(1, "flag mismatch");
        end
    endtask

    task automatic check_bus(input string name, input bus_obs_t exp, input bus_obs_t act);
        if (exp !== act) begin
            $display({"[FAIL] %s bus_en/bus_wen/rdata/bus_wdata: ",
                      "expected %b/%h/%h/%h, actual %b/%h/%h/%h"},
                     name, exp.en, exp.wen, exp.rdata, exp.wdata,
                     act.en, act.wen, act.rdata, act.wdata);
            $display("Verification failed");
            $fatal(1, "bus mismatch");
        end
    endtask

    task automatic write_tlb(input logic wi, input logic wr, input tlb_idx_t idx,
                             input tlb_rec_t rec);
        @(posedge clk);
        en        <= 1'b0; // no lookup while the entries change
        bus_stall <= 1'b0;
        tlb_wi    <= wi;
        tlb_wr    <= wr;
        tlb_index <= idx;
        tlb_wdata <= rec;
        @(posedge clk);
        tlb_wi <= 1'b0;
        tlb_wr <= 1'b0;
        if (wi) begin
            model_tlb[idx] = rec;
        end else if (wr) begin
            model_tlb[model_ptr] = rec;
            model_ptr = (model_ptr == 0) ? tlb_idx_t'(TLB_ENTRIES - 1) : model_ptr - 1'b1;
        end
        last_valid = 1'b0;
    endtask

    task automatic do_access();
        logic [2:0]        seg;
        logic [31:0]       va, st, cfg, pa, wd;
        logic [3:0]        w;
        logic [ASID_W-1:0] a;
        logic              e, xf, mapped, hit, pa_ok, bus_exp, look, done;
        page_lo_t          lo;
        tlb_rsp_t          r, exp_r, act_r;
        tlb_req_t          req;
        bus_obs_t          exp_b;
        int                lat, cyc;
        string             name;
        seg = (rand_bits(1) != 0) ? 3'(rand_bits(3)) : {rand_bits(1) != 0, 2'b00};
        if (seg == 3'b100 && rand_bits(1) != 0) begin
            seg = 3'b110; // favour the kseg2 pool
        end
        va  = {seg, (rand_bits(2) == 0) ? 14'(rand_bits(14)) : 14'd0, 15'(rand_bits(15))};
        w   = (rand_bits(1) != 0) ? 4'(rand_bits(4)) : 4'b0000;
        a   = ASID_W'(rand_bits(1));
        e   = rand_bits(3) != 0;
        xf  = rand_bits(3) == 0;
        st  = rand_bits(32);
        st[ERL_BIT] = rand_bits(3) == 0;
        cfg = rand_bits(32);
        wd  = rand_bits(32);

        // expected result from the segment and TLB rules
        mapped  = !seg[2] || seg[1];
        r       = '0;
        lo      = '0;
        hit     = 1'b0;
        lat     = 0;
        pa      = {3'b000, va[28:0]};
        pa_ok   = 1'b1;
        bus_exp = e && !xf;
        if (mapped && !st[ERL_BIT]) begin
            name    = e ? "mapped access" : "mapped idle";
            pa_ok   = 1'b0;
            bus_exp = 1'b0;
            if (e) begin
                for (int i = 0; i < TLB_ENTRIES; i++) begin
                    if (!hit && model_tlb[i].vpn2 == va[31:13]
                        && (model_tlb[i].global || model_tlb[i].asid == a)) begin
                        hit = 1'b1;
                        lo  = va[12] ? model_tlb[i].lo1 : model_tlb[i].lo0;
                    end
                end
                r.refill   = !hit;
                r.invalid  = hit && !lo.valid;
                r.modified = hit && lo.valid && !lo.dirty && (w != 0);
                pa         = {lo.pfn, va[11:0]};
                pa_ok      = !(r.refill || r.invalid || r.modified);
                r.cached   = pa_ok && lo.cca == CACHE_CCA;
                bus_exp    = pa_ok && !xf;
                req.en     = 1'b1;
                req.store  = w != 0;
                req.vaddr  = va;
                req.asid   = a;
                lat        = (last_valid && last_req == req) ? 0 : 1; // one stall unless held
                last_req   = req;
                last_valid = 1'b1;
            end
        end else begin
            name     = mapped ? "erl access" : (seg[0] ? "kseg1 access" : "kseg0 access");
            r.cached = !mapped && !seg[0] && cfg[K0_LSB +: 3] == CACHE_CCA;
        end

        @(posedge clk);
        en         <= e;
        wen        <= w;
        vaddr      <= va;
        wdata      <= wd;
        asid       <= a;
        exc_flag   <= xf;
        cp0_status <= st;
        cp0_config <= cfg;
        bus_stall  <= rand_bits(2) == 0;
        bus_rdata  <= rand_bits(32);
        cyc  = 0;
        done = 1'b0;
        while (!done) begin
            @(negedge clk);
            look = cyc < lat; // lookup still pending
            if (look) begin
                exp_r = '0;
            end else begin
                exp_r = r;
            end
            exp_r.rdy       = !(bus_stall || look);
            act_r.rdy       = !stall;
            act_r.paddr     = '0;
            act_r.cached    = bus_cached && pa_ok && !look;
            act_r.refill    = exc_refill;
            act_r.invalid   = exc_invalid;
            act_r.modified  = exc_modified;
            check_rsp(name, exp_r, act_r);
            exp_b.en    = bus_exp && !look;
            exp_b.wen   = e ? w : 4'b0000;
            exp_b.rdata = e ? bus_rdata : 32'h0;
            exp_b.wdata = wd;
            check_bus(name, exp_b, {bus_en, bus_wen, rdata, bus_wdata});
            if (pa_ok && !look) begin
                check_paddr(name, pa, bus_paddr);
            end
            if (stall) begin
                @(posedge clk);
                bus_stall <= rand_bits(2) == 0;
                bus_rdata <= rand_bits(32);
                cyc++;
            end else begin
                done = 1'b1;
            end
        end
    endtask

    initial begin
        logic [2:0] op;
        rst_n      = 1'b0;
        en         = 1'b0;
        wen        = 4'b0000;
        vaddr      = '0;
        wdata      = '0;
        bus_rdata  = '0;
        bus_stall  = 1'b0;
        asid       = '0;
        exc_flag   = 1'b0;
        cp0_status = '0;
        cp0_config = '0;
        tlb_wi     = 1'b0;
        tlb_wr     = 1'b0;
        tlb_index  = '0;
        tlb_wdata  = '0;
        for (int i = 0; i < TLB_ENTRIES; i++) begin
            model_tlb[i] = '0; // entries reset invalid
        end
        model_ptr  = tlb_idx_t'(TLB_ENTRIES - 1);
        last_valid = 1'b0;
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;

        for (int i = 0; i < TLB_ENTRIES; i++) begin
            write_tlb(1'b1, 1'b0, tlb_idx_t'(i), rand_rec());
        end
        for (int n = 0; n < N_OPS; n++) begin
            op = 3'(rand_bits(3));
            if (op == 3'd0) begin
                write_tlb(1'b0, 1'b1, '0, rand_rec()); // replacement write
            end else if (op == 3'd1) begin
                write_tlb(1'b1, rand_bits(1) != 0, tlb_idx_t'(rand_bits(3)), rand_rec());
            end else begin
                do_access();
            end
        end
        $display("Verification passed");
        $finish;
    end

endmodule

// ==== tb/mmu_assert.sv ====
// MMU assertions
// Concurrent checks on the stall and exception outputs, bound into the MMU top level.
`timescale 1ns/1ps

module mmu_assert
    import mmu_pkg::*;
(
    input logic     clk,
    input logic     rst_n,
    input tlb_req_t tlb_req,
    input logic     flush,
    input logic     bus_stall,
    input logic     bus_en,
    input logic     stall,
    input logic     exc_refill,
    input logic     exc_invalid,
    input logic     exc_modified
);

    assert property (@(posedge clk) disable iff (!rst_n)
        $onehot0({exc_refill, exc_invalid, exc_modified}))
        else $error("more than one exception output high");

    // stall without bus_stall means the lookup is pending
    assert property (@(posedge clk) disable iff (!rst_n)
        (tlb_req.en && stall && !bus_stall) |-> !bus_en)
        else $error("bus_en high while a mapped lookup is pending");

    // held request is ready after its first cycle
    assert property (@(posedge clk) disable iff (!rst_n)
        (tlb_req.en && tlb_req == $past(tlb_req) && !$past(flush) && $past(rst_n)
         && !bus_stall) |-> !stall)
        else $error("held mapped request still stalls");

endmodule

bind mmu_top mmu_assert mmu_assert_i (
    .clk          (clk),
    .rst_n        (rst_n),
    .tlb_req      (tlb_req),
    .flush        (flush),
    .bus_stall    (bus_stall),
    .bus_en       (bus_en),
    .stall        (stall),
    .exc_refill   (exc_refill),
    .exc_invalid  (exc_invalid),
    .exc_modified (exc_modified)
);

// ==== verilog/mmu_top.sv ====
// MMU top level
// Joins the translation logic, the TLB write port, the entry array and the lookup.
`timescale 1ns/1ps

module mmu_top
    import mmu_pkg::*;
(
    input  logic              clk,
    input  logic              rst_n,
    input  logic              en,
    input  logic [3:0]        wen,
    input  logic [31:0]       vaddr,
    input  logic [31:0]       wdata,
    output logic [31:0]       rdata,
    output logic              bus_en,
    output logic [3:0]        bus_wen,
    output logic [31:0]       bus_paddr,
    output logic [31:0]       bus_wdata,
    input  logic [31:0]       bus_rdata,
    input  logic              bus_stall,
    output logic              bus_cached,
    input  logic [ASID_W-1:0] asid,
    input  logic              exc_flag,
    input  logic [31:0]       cp0_status,
    input  logic [31:0]       cp0_config,
    output logic              exc_refill,
    output logic              exc_invalid,
    output logic              exc_modified,
    output logic              stall,
    input  logic              tlb_wi,
    input  logic              tlb_wr,
    input  tlb_idx_t          tlb_index,
    input  tlb_rec_t          tlb_wdata
);

    tlb_req_t               tlb_req;
    tlb_rsp_t               tlb_rsp;
    logic [TLB_ENTRIES-1:0] entry_we;
    tlb_rec_t               entry_rec;
    logic                   flush;
    tlb_hit_t               entry_hit [TLB_ENTRIES];

    mmu mmu_i (
        .en           (en),
        .wen          (wen),
        .vaddr        (vaddr),
        .wdata        (wdata),
        .rdata        (rdata),
        .bus_en       (bus_en),
        .bus_wen      (bus_wen),
        .bus_paddr    (bus_paddr),
        .bus_wdata    (bus_wdata),
        .bus_rdata    (bus_rdata),
        .bus_stall    (bus_stall),
        .bus_cached   (bus_cached),
        .asid         (asid),
        .exc_flag     (exc_flag),
        .cp0_status   (cp0_status),
        .cp0_config   (cp0_config),
        .exc_refill   (exc_refill),
        .exc_invalid  (exc_invalid),
        .exc_modified (exc_modified),
        .stall        (stall),
        .tlb_req      (tlb_req),
        .tlb_rsp      (tlb_rsp)
    );

    tlb_write_port wport_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .tlb_wi    (tlb_wi),
        .tlb_wr    (tlb_wr),
        .tlb_index (tlb_index),
        .tlb_wdata (tlb_wdata),
        .entry_we  (entry_we),
        .entry_rec (entry_rec),
        .flush     (flush)
    );

    for (genvar i = 0; i < TLB_ENTRIES; i++) begin : g_entry
        tlb_entry entry_i (
            .clk   (clk),
            .rst_n (rst_n),
            .we    (entry_we[i]),
            .wrec  (entry_rec),
            .req   (tlb_req),
            .hit   (entry_hit[i])
        );
    end

    tlb_lookup lookup_i (
        .clk   (clk),
        .rst_n (rst_n),
        .req   (tlb_req),
        .hits  (entry_hit),
        .flush (flush),
        .rsp   (tlb_rsp)
    );

endmodule

// ==== verilog/mmu.sv ====
// MMU data-port translation
// Decodes the segment, maps unmapped segments directly and steers mapped ones to the TLB.
`timescale 1ns/1ps

module mmu
    import mmu_pkg::*;
(
    input  logic              en,
    input  logic [3:0]        wen,
    input  logic [31:0]       vaddr,
    input  logic [31:0]       wdata,
    output logic [31:0]       rdata,

    output logic              bus_en,
    output logic [3:0]        bus_wen,
    output logic [31:0]       bus_paddr,
    output logic [31:0]       bus_wdata,
    input  logic [31:0]       bus_rdata,
    input  logic              bus_stall,
    output logic              bus_cached,

    input  logic [ASID_W-1:0] asid,
    input  logic              exc_flag,
    input  logic [31:0]       cp0_status,
    input  logic [31:0]       cp0_config,
    output logic              exc_refill,
    output logic              exc_invalid,
    output logic              exc_modified,
    output logic              stall,

    output tlb_req_t          tlb_req,
    input  tlb_rsp_t          tlb_rsp
);

    vaddr_u      va;
    seg_e        seg;
    logic        erl;
    logic [2:0]  k0;
    logic [31:0] direct_pa;
    logic        tlb_fault;
    logic        tlb_stall;

    assign va        = vaddr;
    assign erl       = cp0_status[ERL_BIT];
    assign k0        = cp0_config[K0_LSB +: 3];
    assign direct_pa = {3'b000, va.s.off};
    assign tlb_fault = tlb_rsp.refill || tlb_rsp.invalid || tlb_rsp.modified;

    // top bit clear means kuseg
    always_comb begin
        if (!va.s.seg[2]) begin
            seg = SEG_KUSEG;
        end else begin
            seg = seg_e'(va.s.seg);
        end
    end

    always_comb begin
        tlb_req      = '0;
        tlb_stall    = 1'b0;
        bus_en       = 1'b0;
        bus_paddr    = '0;
        bus_cached   = 1'b0;
        exc_refill   = 1'b0;
        exc_invalid  = 1'b0;
        exc_modified = 1'b0;

        case (seg)
            SEG_KSEG0: begin
                bus_paddr  = direct_pa;
                bus_en     = en && !exc_flag;
                bus_cached = k0 == CACHE_CCA; // cacheability from Config.K0
            end
            SEG_KSEG1: begin
                bus_paddr = direct_pa; // always uncached
                bus_en    = en && !exc_flag;
            end
            SEG_KUSEG, SEG_KSEG2, SEG_KSEG3: begin
                if (erl) begin
                    // error level maps like kseg1
                    bus_paddr = direct_pa;
                    bus_en    = en && !exc_flag;
                end else if (en) begin
                    tlb_req.en    = 1'b1;
                    tlb_req.store = |wen;
                    tlb_req.vaddr = va;
                    tlb_req.asid  = asid;
                    tlb_stall     = !tlb_rsp.rdy; // first cycle waits for the lookup
                    if (tlb_rsp.rdy) begin
                        bus_paddr    = tlb_rsp.paddr;
                        bus_cached   = tlb_rsp.cached;
                        bus_en       = !exc_flag && !tlb_fault;
                        exc_refill   = tlb_rsp.refill;
                        exc_invalid  = tlb_rsp.invalid;
                        exc_modified = tlb_rsp.modified;
                    end
                end
            end
            default: begin
                bus_en = 1'b0;
            end
        endcase
    end

    assign bus_wen   = en ? wen : 4'b0000;
    assign bus_wdata = wdata;
    assign rdata     = en ? bus_rdata : 32'h0;
    assign stall     = bus_stall || tlb_stall;

endmodule

// ==== verilog/tlb_lookup.sv ====
// TLB lookup
// Picks the lowest hit, classifies the fault and keeps the result for the held request.
`timescale 1ns/1ps

module tlb_lookup
    import mmu_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,
    input  tlb_req_t req,
    input  tlb_hit_t hits [TLB_ENTRIES],
    input  logic     flush,
    output tlb_rsp_t rsp
);

    tlb_hit_t sel;
    logic     any_hit;
    tlb_rsp_t res_d;
    tlb_rsp_t res_q;
    tlb_req_t req_q;
    logic     valid_q;
    logic     rdy;
    logic     load;

    // scan downwards so the lowest index wins
    always_comb begin
        any_hit = 1'b0;
        sel     = '0;
        for (int i = TLB_ENTRIES - 1; i >= 0; i--) begin
            if (hits[i].hit) begin
                any_hit = 1'b1;
                sel     = hits[i];
            end
        end
    end

    always_comb begin
        res_d.rdy      = 1'b0;
        res_d.paddr    = {sel.lo.pfn, req.vaddr.p.poff};
        res_d.cached   = sel.lo.cca == CACHE_CCA;
        res_d.refill   = !any_hit;
        res_d.invalid  = any_hit && !sel.lo.valid;
        res_d.modified = any_hit && sel.lo.valid && req.store && !sel.lo.dirty; // store to clean page
    end

    assign rdy  = valid_q && (req_q == req);
    assign load = req.en && !rdy; // a ready request is not looked up again

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_q <= 1'b0;
        end else if (flush) begin
            valid_q <= 1'b0;
        end else if (load) begin
            valid_q <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            req_q <= req;
            res_q <= res_d;
        end
    end

    always_comb begin
        rsp     = res_q;
        rsp.rdy = rdy;
    end

endmodule

// ==== verilog/tlb_write_port.sv ====
// TLB write port
// Turns tlbwi/tlbwr strobes into a one-hot entry write and keeps the replacement pointer.
`timescale 1ns/1ps

module tlb_write_port
    import mmu_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   tlb_wi,
    input  logic                   tlb_wr,
    input  tlb_idx_t               tlb_index,
    input  tlb_rec_t               tlb_wdata,
    output logic [TLB_ENTRIES-1:0] entry_we,
    output tlb_rec_t               entry_rec,
    output logic                   flush
);

    tlb_idx_t rep_ptr;
    logic     rep_step;

    assign rep_step = tlb_wr && !tlb_wi; // indexed write wins

    always_comb begin
        entry_we = '0;
        if (tlb_wi) begin
            entry_we[tlb_index] = 1'b1;
        end else if (tlb_wr) begin
            entry_we[rep_ptr] = 1'b1;
        end
    end

    assign entry_rec = tlb_wdata;
    assign flush     = tlb_wi || tlb_wr; // drop any registered lookup

    // replacement pointer counts down and wraps to the top entry
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rep_ptr <= tlb_idx_t'(TLB_ENTRIES - 1);
        end else if (rep_step) begin
            if (rep_ptr == '0) begin
                rep_ptr <= tlb_idx_t'(TLB_ENTRIES - 1);
            end else begin
                rep_ptr <= rep_ptr - 1'b1;
            end
        end
    end

endmodule

// ==== verilog/tlb_entry.sv ====
// TLB entry
// Holds one even/odd page pair and matches it against the requested VPN2 and ASID.
`timescale 1ns/1ps

module tlb_entry
    import mmu_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,
    input  logic     we,
    input  tlb_rec_t wrec,
    input  tlb_req_t req,
    output tlb_hit_t hit
);

    tlb_rec_t rec;
    logic     vpn_match;
    logic     asid_match;

    // entry comes out of reset invalid, vpn2 zero, not global
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rec <= '0;
        end else if (we) begin
            rec <= wrec;
        end
    end

    assign vpn_match  = rec.vpn2 == req.vaddr.p.vpn2;
    assign asid_match = rec.global || (rec.asid == req.asid); // global ignores asid

    always_comb begin
        hit.hit = vpn_match && asid_match;
        if (req.vaddr.p.odd) begin
            hit.lo = rec.lo1;
        end else begin
            hit.lo = rec.lo0;
        end
    end

endmodule

// ==== verilog/mmu_pkg.sv ====
// MMU package
// Shared address, segment and TLB-entry types and constants for the data-port MMU.
package mmu_pkg;

    localparam int TLB_ENTRIES = 8;
    localparam int TLB_IDX_W   = 3;
    localparam int ASID_W      = 8;
    localparam logic [2:0] CACHE_CCA = 3'd3; // cacheable, noncoherent

    localparam int ERL_BIT = 2; // Status.ERL
    localparam int K0_LSB  = 0; // Config.K0 is bits 2:0

    typedef logic [TLB_IDX_W-1:0] tlb_idx_t;

    // segment view of a virtual address
    typedef struct packed {
        logic [2:0]  seg;
        logic [28:0] off;
    } seg_view_t;

    // page view of a virtual address, 4 KB pages in even/odd pairs
    typedef struct packed {
        logic [18:0] vpn2;
        logic        odd;
        logic [11:0] poff;
    } page_view_t;

    typedef union packed {
        seg_view_t  s;
        page_view_t p;
    } vaddr_u;

    typedef enum logic [2:0] {
        SEG_KUSEG = 3'b000, // covers 000..011
        SEG_KSEG0 = 3'b100,
        SEG_KSEG1 = 3'b101,
        SEG_KSEG2 = 3'b110,
        SEG_KSEG3 = 3'b111
    } seg_e;

    typedef struct packed {
        logic [19:0] pfn;
        logic [2:0]  cca;
        logic        dirty;
        logic        valid;
    } page_lo_t;

    typedef struct packed {
        logic [18:0]       vpn2;
        logic [ASID_W-1:0] asid;
        logic              global;
        page_lo_t          lo0; // even page
        page_lo_t          lo1; // odd page
    } tlb_rec_t;

    typedef struct packed {
        logic     hit;
        page_lo_t lo;
    } tlb_hit_t;

    typedef struct packed {
        logic              en;
        logic              store;
        vaddr_u            vaddr;
        logic [ASID_W-1:0] asid;
    } tlb_req_t;

    typedef struct packed {
        logic        rdy;
        logic [31:0] paddr;
        logic        cached;
        logic        refill;
        logic        invalid;
        logic        modified;
    } tlb_rsp_t;

endpackage
